/* project.f */
design/pkt_app_pkg.sv
design/stream_mux.sv
design/meta_proc.sv
design/pkt_drop.sv
design/pkt_trunc.sv
design/pkt_app.sv
tests/tb_clock_gen.sv
tests/pkt_app_tb.sv

/* Makefile */
# Verilator build and run for the pkt_app testbench.

VERILATOR ?= verilator
TOP       ?= pkt_app_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

SOURCES := $(wildcard design/*.sv tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tests/pkt_app_tb.sv */
`timescale 1ns/100ps

module pkt_app_tb;
   import pkt_app_pkg::*;

   logic         core_clk;
   logic         rst_n;
   proc_cfg_t    cfg;
   logic         rx_valid   [NUM_PORTS];
   logic         rx_ready   [NUM_PORTS];
   stream_beat_t rx_beat    [NUM_PORTS];
   logic         tx_valid   [NUM_PORTS];
   logic         tx_ready   [NUM_PORTS];
   stream_beat_t tx_beat    [NUM_PORTS];
   logic [15:0]  drop_count [NUM_PORTS];

   // beats waiting to go in, and beats the model expects out.
   stream_beat_t rx_q  [NUM_PORTS][$];
   stream_beat_t exp_q [NUM_PORTS][$];
   logic         rx_fire   [NUM_PORTS];
   int           exp_drops [NUM_PORTS];
   logic [7:0]   pkt_bytes [$];
   logic [31:0]  rng_state;
   logic         random_mode;
   int           errors;
   int           base_errors;
   int           tests_run;
   int           tests_failed;

   tb_clock_gen u_clk (
      .core_clk (core_clk),
      .rst_n    (rst_n)
   );

   pkt_app DUT (
      .core_clk   (core_clk),
      .rst_n      (rst_n),
      .cfg        (cfg),
      .rx_valid   (rx_valid),
      .rx_ready   (rx_ready),
      .rx_beat    (rx_beat),
      .tx_valid   (tx_valid),
      .tx_ready   (tx_ready),
      .tx_beat    (tx_beat),
      .drop_count (drop_count)
   );

   // ------------------------------
   // helpers
   // ------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic logic [DATA_BYTES*8-1:0] keep_mask(input logic [DATA_BYTES-1:0] keep);
      logic [DATA_BYTES*8-1:0] m;
      for (int i = 0; i < DATA_BYTES; i++) begin
         m[i*8 +: 8] = {8{keep[i]}};
      end
      return m;
   endfunction

   function automatic proc_cfg_t base_cfg();
      proc_cfg_t c;
      c = '0;
      c.drop_loop_en = 1'b1;
      // cross routing, so no port loops back.
      c.route[0] = 1'b1;
      c.route[1] = 1'b0;
      return c;
   endfunction

   // beat b of pkt_bytes, limited to the first n bytes.
   function automatic stream_beat_t make_beat(input int p, input int b, input int n,
                                              input logic last);
      stream_beat_t beat;
      beat      = '0;
      beat.tid  = port_t'(p);
      beat.last = last;
      for (int lane = 0; lane < DATA_BYTES; lane++) begin
         if (b * DATA_BYTES + lane < n) begin
            beat.data[lane*8 +: 8] = pkt_bytes[b * DATA_BYTES + lane];
            beat.keep[lane]        = 1'b1;
         end
      end
      return beat;
   endfunction

   // queues one packet and predicts what leaves on its ingress port.
   task automatic send_packet(input int p, input int nbytes);
      stream_beat_t beat;
      int           out_len;
      int           nbeats;
      pkt_bytes.delete();
      for (int i = 0; i < nbytes; i++) begin
         pkt_bytes.push_back(8'(next_rand()));
      end
      nbeats = (nbytes == 0) ? 1 : (nbytes + DATA_BYTES - 1) / DATA_BYTES;
      for (int b = 0; b < nbeats; b++) begin
         rx_q[p].push_back(make_beat(p, b, nbytes, b == nbeats - 1));
      end
      if (nbytes == 0 || (cfg.drop_loop_en && cfg.route[p] == port_t'(p))) begin
         exp_drops[p]++;
      end else begin
         out_len = nbytes;
         if (cfg.trunc_enable[p] && int'(cfg.trunc_length[p]) < out_len) begin
            out_len = int'(cfg.trunc_length[p]);
         end
         nbeats = (out_len + DATA_BYTES - 1) / DATA_BYTES;
         for (int b = 0; b < nbeats; b++) begin
            beat                   = make_beat(p, b, out_len, b == nbeats - 1);
            beat.tdest             = cfg.route[p];
            beat.meta.egress_port  = cfg.route[p];
            beat.meta.trunc_enable = cfg.trunc_enable[p];
            beat.meta.trunc_length = cfg.trunc_length[p];
            exp_q[p].push_back(beat);
         end
      end
   endtask

   task automatic check_beat(input int p, input stream_beat_t got);
      stream_beat_t            want;
      logic [DATA_BYTES*8-1:0] mask;
      if (exp_q[p].size() == 0) begin
         errors++;
         $display("ERR at %0t: port %0d sent a beat the model did not expect", $time, p);
      end else begin
         want = exp_q[p].pop_front();
         mask = keep_mask(want.keep);
         if (got.keep !== want.keep || got.last !== want.last || got.tid !== want.tid ||
             got.tdest !== want.tdest || got.meta !== want.meta ||
             (got.data & mask) !== (want.data & mask)) begin
            errors++;
            $display("ERR at %0t: port %0d got keep %h last %b tdest %0d data %h",
                     $time, p, got.keep, got.last, got.tdest, got.data & mask);
            $display("ERR at %0t: port %0d want keep %h last %b tdest %0d data %h",
                     $time, p, want.keep, want.last, want.tdest, want.data & mask);
         end
      end
   endtask

   function automatic int outstanding();
      int n;
      n = 0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         n = n + rx_q[p].size() + exp_q[p].size();
         if (drop_count[p] != 16'(exp_drops[p])) begin
            n = n + 1;
         end
      end
      return n;
   endfunction

   task automatic wait_drain(input string what, input int limit);
      int cycles;
      cycles = 0;
      while (outstanding() != 0 && cycles < limit) begin
         @(negedge core_clk);
         cycles++;
      end
      if (outstanding() != 0) begin
         errors++;
         $display("%s timed out after %0d cycles with beats or drops still missing",
                  what, limit);
      end
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge core_clk);
   endtask

   task automatic apply_cfg(input proc_cfg_t c);
      @(posedge core_clk);
      cfg <= c;
      @(negedge core_clk);
   endtask

   task automatic report_test(input string name);
      idle(4);
      tests_run++;
      if (errors == base_errors) begin
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - base_errors);
      end
      base_errors = errors;
   endtask

   // ------------------------------
   // stream driver and monitor
   // ------------------------------
   initial begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         rx_valid[p] <= 1'b0;
         rx_beat[p]  <= '0;
         tx_ready[p] <= 1'b1;
      end
      forever begin
         // handshakes are judged mid-cycle and take effect at the next edge.
         @(negedge core_clk);
         for (int p = 0; p < NUM_PORTS; p++) begin
            rx_fire[p] = rx_valid[p] && rx_ready[p];
            if (tx_valid[p] && tx_ready[p]) begin
               check_beat(p, tx_beat[p]);
            end
         end
         @(posedge core_clk);
         for (int p = 0; p < NUM_PORTS; p++) begin
            if (rx_fire[p]) begin
               void'(rx_q[p].pop_front());
            end
            if (!rx_valid[p] || rx_fire[p]) begin
               if (rx_q[p].size() > 0 && (!random_mode || next_rand() > 32'h5fff_ffff)) begin
                  rx_valid[p] <= 1'b1;
                  rx_beat[p]  <= rx_q[p][0];
               end else begin
                  rx_valid[p] <= 1'b0;
               end
            end
            tx_ready[p] <= random_mode ? (next_rand() > 32'h7fff_ffff) : 1'b1;
         end
      end
   end

   // ------------------------------
   // directed tests
   // ------------------------------
   task automatic forward_and_route();
      int lens [6] = '{1, 8, 9, 17, 24, 33};
      apply_cfg(base_cfg());
      for (int i = 0; i < 6; i++) begin
         send_packet(0, lens[i]);
         send_packet(1, lens[5 - i] + 3);
      end
      wait_drain("forwarding", 1000);
      report_test("forwarding and routing");
   endtask

   task automatic drop_zero_length();
      send_packet(0, 10);
      send_packet(0, 0);
      send_packet(0, 12);
      send_packet(1, 7);
      wait_drain("zero-length drop", 1000);
      report_test("zero-length drop");
   endtask

   task automatic drop_loops();
      proc_cfg_t c;
      c          = base_cfg();
      c.route[0] = 1'b0;
      apply_cfg(c);
      send_packet(0, 20);
      send_packet(0, 4);
      send_packet(1, 9);
      wait_drain("loop drop", 1000);
      c.drop_loop_en = 1'b0;
      apply_cfg(c);
      send_packet(0, 20);
      send_packet(1, 9);
      wait_drain("loop pass", 1000);
      report_test("loop drop");
   endtask

   task automatic truncate_packets();
      int        lens [4] = '{5, 12, 16, 100};
      proc_cfg_t c;
      for (int i = 0; i < 4; i++) begin
         c                 = base_cfg();
         c.trunc_enable    = '1;
         c.trunc_length[0] = 16'(lens[i]);
         c.trunc_length[1] = 16'(lens[i]);
         apply_cfg(c);
         send_packet(0, 20);
         send_packet(1, 20);
         send_packet(0, 3);
         send_packet(1, 3);
         wait_drain("truncation", 1000);
      end
      apply_cfg(base_cfg());
      report_test("truncation");
   endtask

   task automatic hold_on_pause();
      proc_cfg_t c;
      logic      seen;
      c       = base_cfg();
      c.pause = 1'b1;
      apply_cfg(c);
      send_packet(0, 11);
      send_packet(1, 25);
      send_packet(0, 6);
      seen = 1'b0;
      for (int i = 0; i < 40; i++) begin
         @(negedge core_clk);
         if (tx_valid[0] || tx_valid[1]) begin
            seen = 1'b1;
         end
      end
      if (seen) begin
         errors++;
         $display("ERR at %0t: a tx beat left while pause was high", $time);
      end
      apply_cfg(base_cfg());
      wait_drain("pause release", 1000);
      report_test("pause");
   endtask

   task automatic stress_backpressure();
      random_mode = 1'b1;
      for (int i = 0; i < 12; i++) begin
         send_packet(0, 1 + int'(next_rand() % 32'd40));
         send_packet(1, 1 + int'(next_rand() % 32'd40));
      end
      wait_drain("back-pressure", 5000);
      random_mode = 1'b0;
      report_test("back-pressure and concurrency");
   endtask

   initial begin
      int cycles;
      rng_state    = 32'h526a_923c;
      random_mode  = 1'b0;
      errors       = 0;
      base_errors  = 0;
      tests_run    = 0;
      tests_failed = 0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         exp_drops[p] = 0;
      end
      cfg <= base_cfg();
      cycles = 0;
      while (rst_n !== 1'b1 && cycles < 100) begin
         @(negedge core_clk);
         cycles++;
      end
      if (rst_n !== 1'b1) begin
         errors++;
         $display("reset was never released");
      end
      forward_and_route();
      drop_zero_length();
      drop_loops();
      truncate_packets();
      hold_on_pause();
      stress_backpressure();
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
   output logic core_clk,
   output logic rst_n
);

   // 8 ns period.
   initial begin
      core_clk = 1'b0;
      forever #4 core_clk = ~core_clk;
   end

   initial begin
      rst_n <= 1'b0;
      repeat (8) @(posedge core_clk);
      rst_n <= 1'b1;
   end

endmodule

/* design/pkt_app.sv */
`timescale 1ns/100ps

module pkt_app (
   input  logic                      core_clk,
   input  logic                      rst_n,
   input  pkt_app_pkg::proc_cfg_t    cfg,
   input  logic                      rx_valid   [pkt_app_pkg::NUM_PORTS],
   output logic                      rx_ready   [pkt_app_pkg::NUM_PORTS],
   input  pkt_app_pkg::stream_beat_t rx_beat    [pkt_app_pkg::NUM_PORTS],
   output logic                      tx_valid   [pkt_app_pkg::NUM_PORTS],
   input  logic                      tx_ready   [pkt_app_pkg::NUM_PORTS],
   output pkt_app_pkg::stream_beat_t tx_beat    [pkt_app_pkg::NUM_PORTS],
   output logic [15:0]               drop_count [pkt_app_pkg::NUM_PORTS]
);
   import pkt_app_pkg::*;

   logic         mux_valid;
   logic         mux_ready;
   stream_beat_t mux_beat;
   logic         proc_valid;
   logic         proc_ready;
   stream_beat_t proc_beat;
   logic         chain_valid [NUM_PORTS];
   logic         chain_ready [NUM_PORTS];
   logic         drop_valid  [NUM_PORTS];
   logic         drop_ready  [NUM_PORTS];
   stream_beat_t drop_beat   [NUM_PORTS];

   // ------------------------------
   // shared path
   // ------------------------------
   stream_mux u_mux (
      .core_clk  (core_clk),
      .rst_n     (rst_n),
      .in_valid  (rx_valid),
      .in_ready  (rx_ready),
      .in_beat   (rx_beat),
      .out_valid (mux_valid),
      .out_ready (mux_ready),
      .out_beat  (mux_beat)
   );

   meta_proc u_proc (
      .core_clk  (core_clk),
      .rst_n     (rst_n),
      .cfg       (cfg),
      .in_valid  (mux_valid),
      .in_ready  (mux_ready),
      .in_beat   (mux_beat),
      .out_valid (proc_valid),
      .out_ready (proc_ready),
      .out_beat  (proc_beat)
   );

   // packets go back to the port they came in on.
   assign proc_ready = chain_ready[proc_beat.tid];

   // ------------------------------
   // per port drop and truncation
   // ------------------------------
   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
      assign chain_valid[i] = proc_valid && (proc_beat.tid == port_t'(i));

      pkt_drop u_drop (
         .core_clk     (core_clk),
         .rst_n        (rst_n),
         .drop_loop_en (cfg.drop_loop_en),
         .in_valid     (chain_valid[i]),
         .in_ready     (chain_ready[i]),
         .in_beat      (proc_beat),
         .out_valid    (drop_valid[i]),
         .out_ready    (drop_ready[i]),
         .out_beat     (drop_beat[i]),
         .drop_count   (drop_count[i])
      );

      pkt_trunc u_trunc (
         .core_clk  (core_clk),
         .rst_n     (rst_n),
         .in_valid  (drop_valid[i]),
         .in_ready  (drop_ready[i]),
         .in_beat   (drop_beat[i]),
         .out_valid (tx_valid[i]),
         .out_ready (tx_ready[i]),
         .out_beat  (tx_beat[i])
      );
   end

endmodule

/* design/pkt_trunc.sv */
`timescale 1ns/100ps

module pkt_trunc (
   input  logic                      core_clk,
   input  logic                      rst_n,
   input  logic                      in_valid,
   output logic                      in_ready,
   input  pkt_app_pkg::stream_beat_t in_beat,
   output logic                      out_valid,
   input  logic                      out_ready,
   output pkt_app_pkg::stream_beat_t out_beat
);
   import pkt_app_pkg::*;

   logic                      load_ok;
   logic                      in_fire;
   logic                      tail;
   logic [LEN_WIDTH-1:0]      length;
   logic [BYTE_CNT_WIDTH-1:0] bytes_before;
   logic [BYTE_CNT_WIDTH-1:0] beat_bytes;
   logic [BYTE_CNT_WIDTH-1:0] end_count;
   logic [BYTE_CNT_WIDTH-1:0] remaining;
   logic                      cut;
   logic                      emit;
   stream_beat_t              trim_beat;

   assign load_ok  = !out_valid || out_ready;
   assign in_ready = tail || load_ok;
   assign in_fire  = in_valid && in_ready;

   // no truncation means an all-ones length.
   assign length = in_beat.meta.trunc_enable ? in_beat.meta.trunc_length : '1;

   // ------------------------------
   // byte accounting
   // ------------------------------
   always_comb begin
      beat_bytes = '0;
      for (int i = 0; i < DATA_BYTES; i++) begin
         beat_bytes = beat_bytes + BYTE_CNT_WIDTH'(in_beat.keep[i]);
      end
   end

   assign end_count = bytes_before + beat_bytes;
   assign remaining = BYTE_CNT_WIDTH'(length) - bytes_before;
   assign cut       = !tail && (end_count >= BYTE_CNT_WIDTH'(length));
   // a zero length leaves nothing to send on the boundary beat.
   assign emit      = in_valid && !tail && !(cut && remaining == '0);

   always_comb begin
      trim_beat = in_beat;
      if (cut) begin
         trim_beat.last = 1'b1;
         for (int i = 0; i < DATA_BYTES; i++) begin
            trim_beat.keep[i] = in_beat.keep[i] && (BYTE_CNT_WIDTH'(i) < remaining);
         end
      end
   end

   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         tail         <= 1'b0;
         bytes_before <= '0;
      end else if (in_fire) begin
         if (in_beat.last) begin
            tail         <= 1'b0;
            bytes_before <= '0;
         end else if (cut) begin
            tail <= 1'b1;
         end else if (!tail) begin
            bytes_before <= end_count;
         end
      end
   end

   // ------------------------------
   // output register
   // ------------------------------
   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (load_ok) begin
         out_valid <= emit;
      end
   end

   always_ff @(posedge core_clk) begin
      if (in_fire && emit) begin
         out_beat <= trim_beat;
      end
   end

   // holds because the drop stage upstream removes keep-zero packets.
   a_keep_nonzero: assert property (@(posedge core_clk) disable iff (!rst_n)
      out_valid |-> (out_beat.keep != '0))
      else $error("empty beat on output");

endmodule

/* design/pkt_drop.sv */
`timescale 1ns/100ps

module pkt_drop (
   input  logic                      core_clk,
   input  logic                      rst_n,
   input  logic                      drop_loop_en,
   input  logic                      in_valid,
   output logic                      in_ready,
   input  pkt_app_pkg::stream_beat_t in_beat,
   output logic                      out_valid,
   input  logic                      out_ready,
   output pkt_app_pkg::stream_beat_t out_beat,
   output logic [15:0]               drop_count
);
   import pkt_app_pkg::*;

   drop_state_e state;
   logic        load_ok;
   logic        in_fire;
   logic        zero_len;
   logic        loop_pkt;
   logic        drop_now;
   logic        pass_beat;

   assign load_ok  = !out_valid || out_ready;
   // discarded beats are swallowed regardless of the output side.
   assign in_ready = (state == DROP_DISCARD) || load_ok;
   assign in_fire  = in_valid && in_ready;

   assign zero_len  = in_beat.last && (in_beat.keep == '0);
   assign loop_pkt  = drop_loop_en && (in_beat.tdest == in_beat.tid);
   assign drop_now  = (state == DROP_SOP) && (zero_len || loop_pkt);
   assign pass_beat = in_valid && (state != DROP_DISCARD) && !drop_now;

   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= DROP_SOP;
         drop_count <= '0;
      end else if (in_fire) begin
         if (drop_now) begin
            drop_count <= drop_count + 16'd1;
         end
         if (in_beat.last) begin
            state <= DROP_SOP;
         end else if (state == DROP_SOP) begin
            state <= drop_now ? DROP_DISCARD : DROP_PASS;
         end
      end
   end

   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (load_ok) begin
         out_valid <= pass_beat;
      end
   end

   always_ff @(posedge core_clk) begin
      if (in_fire && pass_beat) begin
         out_beat <= in_beat;
      end
   end

   // a beat of a dropped packet never loads the output register.
   a_no_out_discard: assert property (@(posedge core_clk) disable iff (!rst_n)
      (in_fire && (drop_now || state == DROP_DISCARD)) |=> (!out_valid || $stable(out_beat)))
      else $error("beat emitted from a dropped packet");

endmodule

/* design/meta_proc.sv */
`timescale 1ns/100ps

module meta_proc (
   input  logic                      core_clk,
   input  logic                      rst_n,
   input  pkt_app_pkg::proc_cfg_t    cfg,
   input  logic                      in_valid,
   output logic                      in_ready,
   input  pkt_app_pkg::stream_beat_t in_beat,
   output logic                      out_valid,
   input  logic                      out_ready,
   output pkt_app_pkg::stream_beat_t out_beat
);
   import pkt_app_pkg::*;

   logic  gate_valid;
   logic  load_ok;
   logic  in_fire;
   logic  sop;
   meta_t sop_meta;
   meta_t pkt_meta;
   meta_t cur_meta;

   // ------------------------------
   // pause gate
   // ------------------------------
   assign load_ok    = !out_valid || out_ready;
   assign gate_valid = in_valid && !cfg.pause;
   assign in_ready   = load_ok && !cfg.pause;
   assign in_fire    = gate_valid && in_ready;

   // ------------------------------
   // metadata lookup
   // ------------------------------
   // tables are indexed by the ingress port.
   always_comb begin
      sop_meta.egress_port  = cfg.route[in_beat.tid];
      sop_meta.trunc_enable = cfg.trunc_enable[in_beat.tid];
      sop_meta.trunc_length = cfg.trunc_length[in_beat.tid];
   end

   // later beats keep the values seen at sop, even if cfg moves.
   assign cur_meta = sop ? sop_meta : pkt_meta;

   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         sop <= 1'b1;
      end else if (in_fire) begin
         sop <= in_beat.last;
      end
   end

   always_ff @(posedge core_clk) begin
      if (in_fire && sop) begin
         pkt_meta <= sop_meta;
      end
   end

   // ------------------------------
   // output register
   // ------------------------------
   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (load_ok) begin
         out_valid <= gate_valid;
      end
   end

   always_ff @(posedge core_clk) begin
      if (in_fire) begin
         out_beat       <= in_beat;
         out_beat.tdest <= cur_meta.egress_port;
         out_beat.meta  <= cur_meta;
      end
   end

   a_out_hold: assert property (@(posedge core_clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
      else $error("output beat changed while stalled");

endmodule

/* design/stream_mux.sv */
`timescale 1ns/100ps

module stream_mux (
   input  logic                      core_clk,
   input  logic                      rst_n,
   input  logic                      in_valid [pkt_app_pkg::NUM_PORTS],
   output logic                      in_ready [pkt_app_pkg::NUM_PORTS],
   input  pkt_app_pkg::stream_beat_t in_beat  [pkt_app_pkg::NUM_PORTS],
   output logic                      out_valid,
   input  logic                      out_ready,
   output pkt_app_pkg::stream_beat_t out_beat
);
   import pkt_app_pkg::*;

   mux_state_e state;
   port_t      grant;
   port_t      other;
   port_t      pick;
   port_t      sel;
   logic       last_fire;

   // ------------------------------
   // arbitration
   // ------------------------------
   // grant doubles as the last port served, so the other port has priority.
   assign other = grant + port_t'(1);
   assign pick  = in_valid[other] ? other : grant;
   assign sel   = (state == MUX_LOCKED) ? grant : pick;

   assign out_valid = in_valid[sel];
   assign out_beat  = in_beat[sel];
   assign last_fire = out_valid && out_ready && out_beat.last;

   always_comb begin
      for (int i = 0; i < NUM_PORTS; i++) begin
         in_ready[i] = out_ready && (sel == port_t'(i));
      end
   end

   // lock as soon as a beat is shown, so the offered beat cannot switch ports.
   always_ff @(posedge core_clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= MUX_IDLE;
         grant <= '0;
      end else begin
         case (state)
            MUX_IDLE: begin
               if (out_valid) begin
                  grant <= pick;
                  if (!last_fire) begin
                     state <= MUX_LOCKED;
                  end
               end
            end
            MUX_LOCKED: begin
               if (last_fire) begin
                  state <= MUX_IDLE;
               end
            end
            default: state <= MUX_IDLE;
         endcase
      end
   end

   // a packet is never interleaved with the other port.
   a_grant_held: assert property (@(posedge core_clk) disable iff (!rst_n)
      (out_valid && !last_fire) |=> (sel == $past(sel)))
      else $error("grant moved inside a packet");

endmodule

/* design/pkt_app_pkg.sv */
package pkt_app_pkg;

   // ------------------------------
   // sizes
   // ------------------------------
   localparam int NUM_PORTS      = 2;
   localparam int DATA_BYTES     = 8;
   localparam int LEN_WIDTH      = 16;
   // one spare bit so a running byte count can pass an all-ones length.
   localparam int BYTE_CNT_WIDTH = LEN_WIDTH + 1;

   typedef logic [$clog2(NUM_PORTS)-1:0] port_t;

   // ------------------------------
   // stream types
   // ------------------------------
   typedef struct packed {
      port_t                egress_port;
      logic                 trunc_enable;
      logic [LEN_WIDTH-1:0] trunc_length;
   } meta_t;

   // data is little endian, byte 0 sits in bits 7:0.
   typedef struct packed {
      logic [DATA_BYTES*8-1:0] data;
      logic [DATA_BYTES-1:0]   keep;
      logic                    last;
      port_t                   tid;
      port_t                   tdest;
      meta_t                   meta;
   } stream_beat_t;

   // ------------------------------
   // configuration levels
   // ------------------------------
   typedef struct packed {
      logic                                 drop_loop_en;
      logic                                 pause;
      port_t [NUM_PORTS-1:0]                route;
      logic  [NUM_PORTS-1:0]                trunc_enable;
      logic  [NUM_PORTS-1:0][LEN_WIDTH-1:0] trunc_length;
   } proc_cfg_t;

   // ------------------------------
   // fsm states
   // ------------------------------
   typedef enum logic {
      MUX_IDLE,
      MUX_LOCKED
   } mux_state_e;

   typedef enum logic [1:0] {
      DROP_SOP,
      DROP_PASS,
      DROP_DISCARD
   } drop_state_e;

endpackage
